// File: Bender.yml
package:
  name: clk_gen

sources:
  - hw/clk_gen_pkg.sv
  - hw/div_cfg_if.sv
  - hw/clk_div.sv
  - hw/clk_div_channel.sv
  - hw/div_cfg_regs.sv
  - hw/clk_gen_top.sv
  - target: test
    files:
      - tests/clk_gen_tb.sv

// File: hw/clk_div.sv
/* odd/even clock divider with bypass for ratios below 2
   also flags the last cycle before each high phase as a period start */
`timescale 1ns/1ps

module clk_div (
  input  logic              arst_ni,
  input  logic              clk_i,
  input  clk_gen_pkg::div_t div_i,
  output logic              clk_o,
  output logic              period_start_o
);

  ////////////////////////////////////////
  // phase lengths

  // high phase is floor(d/2) cycles
  clk_gen_pkg::div_t high_count;
  // low phase gets the extra cycle for odd d
  clk_gen_pkg::div_t low_count;
  clk_gen_pkg::div_t clk_count;

  logic no_div;
  logic high_done;
  logic low_done;

  // divided clock before the half cycle stretch
  logic state_q;
  // state sampled on the falling edge
  logic fall_q;

  assign high_count = {1'b0, div_i[clk_gen_pkg::DIV_W-1:1]};
  assign low_count  = high_count + clk_gen_pkg::div_t'(div_i[0]);

  // ratio 0 or 1 gives a zero high count
  assign no_div = (high_count == '0);

  assign high_done = (clk_count == high_count - clk_gen_pkg::div_t'(1));
  assign low_done  = (clk_count == low_count - clk_gen_pkg::div_t'(1));

  ////////////////////////////////////////
  // period start

  // high on the cycle whose closing edge raises the state
  // every cycle in bypass since each input edge starts a period
  assign period_start_o = no_div | (~state_q & low_done);

  ////////////////////////////////////////
  // counter

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      state_q   <= 1'b0;
      clk_count <= '0;
    end else if (no_div) begin
      // park at the head of a high phase
      // so leaving bypass begins with a full high phase
      state_q   <= 1'b1;
      clk_count <= '0;
    end else if (state_q) begin
      if (high_done) begin
        clk_count <= '0;
        state_q   <= 1'b0;
      end else begin
        clk_count <= clk_count + clk_gen_pkg::div_t'(1);
      end
    end else begin
      if (low_done) begin
        clk_count <= '0;
        state_q   <= 1'b1;
      end else begin
        clk_count <= clk_count + clk_gen_pkg::div_t'(1);
      end
    end
  end

  // half cycle delayed copy of the state
  always_ff @(negedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      fall_q <= 1'b0;
    end else begin
      fall_q <= state_q;
    end
  end

  ////////////////////////////////////////
  // output select

  // odd ratios hold high half a cycle past the state drop
  // which balances the longer low count
  always_comb begin
    if (no_div) begin
      clk_o = clk_i;
    end else if (div_i[0]) begin
      clk_o = state_q | fall_q;
    end else begin
      clk_o = state_q;
    end
  end

endmodule

// File: hw/clk_div_channel.sv
/* one divided clock output with its active ratio and enable
   new settings are taken up only at a period start, after a commit */
`timescale 1ns/1ps

module clk_div_channel (
  input  logic     clk_i,
  input  logic     arst_ni,
  div_cfg_if.chan  cfg,
  output logic     clk_o
);

  ////////////////////////////////////////
  // signals

  // settings the divider runs on now
  clk_gen_pkg::div_t active_div_q;
  logic              active_en_q;

  // a commit is waiting for a period start
  logic pending_q;

  logic div_clk;
  logic period_start;
  logic take_cfg;
  logic load;

  ////////////////////////////////////////
  // divider

  clk_div clk_div_i (
    .arst_ni        (arst_ni),
    .clk_i          (clk_i),
    .div_i          (active_div_q),
    .clk_o          (div_clk),
    .period_start_o (period_start)
  );

  // an idle channel has no pulse to protect
  assign take_cfg = period_start | ~active_en_q;
  assign load     = pending_q & take_cfg;

  // pulse in the cycle whose edge copies the settings
  assign cfg.loaded = load;

  ////////////////////////////////////////
  // commit tracking

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      pending_q <= 1'b0;
    end else if (cfg.commit) begin
      // a fresh commit wins over a load in the same cycle
      pending_q <= 1'b1;
    end else if (load) begin
      pending_q <= 1'b0;
    end
  end

  // active settings
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      active_div_q <= '0;
      active_en_q  <= 1'b0;
    end else if (load) begin
      active_div_q <= cfg.div;
      active_en_q  <= cfg.en;
    end
  end

  ////////////////////////////////////////
  // output gate

  // enable only moves on the edge where div_clk rises
  // so no runt high phase reaches the pin
  assign clk_o = div_clk & active_en_q;

  // a running divided clock takes new settings only at the close of a low phase
  a_load_in_low : assert property (
    @(posedge clk_i) disable iff (!arst_ni)
    load && active_en_q && (active_div_q > clk_gen_pkg::div_t'(1)) |-> !div_clk
  ) else $error("settings taken up while the divided clock is high");

endmodule

// File: hw/clk_gen_pkg.sv
/* widths, channel count, register map and vector types for the clock generator
   design files refer to these by scoped name */
package clk_gen_pkg;

  ////////////////////////////////////////
  // sizes

  // number of divided clock outputs
  localparam int NUM_CH = 4;
  // bits of one divide ratio
  localparam int DIV_W  = 4;
  localparam int ADDR_W = 3;
  localparam int DATA_W = 8;

  ////////////////////////////////////////
  // types

  typedef logic [DIV_W-1:0]  div_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  // one bit per channel
  typedef logic [NUM_CH-1:0] ch_mask_t;

  ////////////////////////////////////////
  // register map

  // ratio registers live at 0 up to NUM_CH-1
  localparam addr_t ADDR_CTRL = addr_t'(4);
  // enable mask sits in the low NUM_CH bits of ctrl
  localparam int CTRL_COMMIT_BIT = 7;

endpackage

// File: hw/clk_gen_top.sv
/* programmable clock generator with NUM_CH divided outputs from clk_i
   configured through a plain write and read register port */
`timescale 1ns/1ps

module clk_gen_top (
  input  logic                  clk_i,
  input  logic                  arst_ni,
  input  logic                  wr_en_i,
  input  clk_gen_pkg::addr_t    wr_addr_i,
  input  clk_gen_pkg::data_t    wr_data_i,
  input  clk_gen_pkg::addr_t    rd_addr_i,
  output clk_gen_pkg::data_t    rd_data_o,
  output clk_gen_pkg::ch_mask_t ch_clk_o,
  output logic                  busy_o
);

  ////////////////////////////////////////
  // config links

  // one link per output channel
  div_cfg_if cfg [clk_gen_pkg::NUM_CH] ();

  ////////////////////////////////////////
  // register bank

  div_cfg_regs div_cfg_regs_i (
    .clk_i     (clk_i),
    .arst_ni   (arst_ni),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o),
    .busy_o    (busy_o),
    .cfg       (cfg)
  );

  ////////////////////////////////////////
  // channels

  // free running and unaligned to each other
  for (genvar i = 0; i < clk_gen_pkg::NUM_CH; i++) begin : g_ch
    clk_div_channel clk_div_channel_i (
      .clk_i   (clk_i),
      .arst_ni (arst_ni),
      .cfg     (cfg[i]),
      .clk_o   (ch_clk_o[i])
    );
  end

endmodule

// File: hw/div_cfg_if.sv
/* one channel's configuration link between the register bank and a clock channel
   regs side drives ratio, enable and commit; chan side reports the load */
`timescale 1ns/1ps

interface div_cfg_if;

  // pending ratio, applied only after a commit
  clk_gen_pkg::div_t div;
  // pending enable
  logic en;
  // single cycle, shared by all channels
  logic commit;
  // single cycle, config taken up at a period start
  logic loaded;

  modport regs (
    output div,
    output en,
    output commit,
    input  loaded
  );

  modport chan (
    input  div,
    input  en,
    input  commit,
    output loaded
  );

endinterface

// File: hw/div_cfg_regs.sv
/* write and read register bank holding pending ratios and the enable mask
   issues the commit pulse and tracks one busy bit per channel */
`timescale 1ns/1ps

module div_cfg_regs (
  input  logic                  clk_i,
  input  logic                  arst_ni,
  input  logic                  wr_en_i,
  input  clk_gen_pkg::addr_t    wr_addr_i,
  input  clk_gen_pkg::data_t    wr_data_i,
  input  clk_gen_pkg::addr_t    rd_addr_i,
  output clk_gen_pkg::data_t    rd_data_o,
  output logic                  busy_o,
  div_cfg_if.regs               cfg [clk_gen_pkg::NUM_CH]
);

  ////////////////////////////////////////
  // storage

  clk_gen_pkg::div_t     ratio_q [clk_gen_pkg::NUM_CH];
  clk_gen_pkg::ch_mask_t en_mask_q;
  clk_gen_pkg::ch_mask_t busy_q;
  clk_gen_pkg::ch_mask_t loaded;
  logic                  commit_q;
  logic                  ctrl_wr;

  assign ctrl_wr = wr_en_i & (wr_addr_i == clk_gen_pkg::ADDR_CTRL);

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      for (int i = 0; i < clk_gen_pkg::NUM_CH; i++) begin
        ratio_q[i] <= '0;
      end
      en_mask_q <= '0;
      commit_q  <= 1'b0;
    end else begin
      for (int i = 0; i < clk_gen_pkg::NUM_CH; i++) begin
        // upper data bits dropped
        if (wr_en_i && wr_addr_i == clk_gen_pkg::addr_t'(i)) begin
          ratio_q[i] <= wr_data_i[clk_gen_pkg::DIV_W-1:0];
        end
      end
      if (ctrl_wr) begin
        en_mask_q <= wr_data_i[clk_gen_pkg::NUM_CH-1:0];
      end
      // commit bit is a strobe, never stored
      commit_q <= ctrl_wr & wr_data_i[clk_gen_pkg::CTRL_COMMIT_BIT];
    end
  end

  ////////////////////////////////////////
  // busy

  // commit sets every bit, each channel clears its own
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      busy_q <= '0;
    end else if (commit_q) begin
      busy_q <= '1;
    end else begin
      busy_q <= busy_q & ~loaded;
    end
  end

  assign busy_o = |busy_q;

  ////////////////////////////////////////
  // channel links

  for (genvar i = 0; i < clk_gen_pkg::NUM_CH; i++) begin : g_cfg
    assign cfg[i].div    = ratio_q[i];
    assign cfg[i].en     = en_mask_q[i];
    assign cfg[i].commit = commit_q;
    assign loaded[i]     = cfg[i].loaded;

    // a channel only loads what a commit handed it
    a_loaded_busy : assert property (
      @(posedge clk_i) disable iff (!arst_ni)
      cfg[i].loaded |-> busy_q[i]
    ) else $error("loaded pulse on channel %0d while not busy", i);
  end

  // readback, unmapped addresses give zero
  always_comb begin
    rd_data_o = '0;
    for (int i = 0; i < clk_gen_pkg::NUM_CH; i++) begin
      if (rd_addr_i == clk_gen_pkg::addr_t'(i)) begin
        rd_data_o = clk_gen_pkg::data_t'(ratio_q[i]);
      end
    end
    if (rd_addr_i == clk_gen_pkg::ADDR_CTRL) begin
      rd_data_o = clk_gen_pkg::data_t'(en_mask_q);
    end
  end

  // back to back commits point at a misbehaving writer
  a_commit_single : assert property (
    @(posedge clk_i) disable iff (!arst_ni)
    commit_q |=> !commit_q
  ) else $error("commit pulse held for two cycles");

endmodule

// File: tests/clk_gen_tb.sv
/* testbench for the clock generator, applies a table of ratio settings
   and measures each output's half periods, plus register readback */
`timescale 1ns/1ps

module clk_gen_tb;

  ////////////////////////////////////////
  // limits

  localparam int NUM_ROWS  = 16;
  localparam int NUM_FIXED = 12;
  // register access, busy wait and three periods of ratio 15
  localparam int ROW_CYCLES = 40 + 3 * 15;
  localparam int MAX_CYCLES = NUM_ROWS * ROW_CYCLES + 50;
  // longer than any legal phase in half cycles
  localparam int MAX_HALF = 40;

  logic                  clk_i;
  logic                  arst_ni;
  logic                  wr_en_i;
  clk_gen_pkg::addr_t    wr_addr_i;
  clk_gen_pkg::data_t    wr_data_i;
  clk_gen_pkg::addr_t    rd_addr_i;
  clk_gen_pkg::data_t    rd_data_o;
  clk_gen_pkg::ch_mask_t ch_clk_o;
  logic                  busy_o;

  // stimulus table
  string             row_name   [NUM_ROWS];
  int                row_ch     [NUM_ROWS];
  clk_gen_pkg::div_t row_div    [NUM_ROWS];
  logic              row_en     [NUM_ROWS];
  logic              row_commit [NUM_ROWS];

  // expected state of registers and channels
  clk_gen_pkg::div_t     pend_div [clk_gen_pkg::NUM_CH];
  clk_gen_pkg::div_t     act_div  [clk_gen_pkg::NUM_CH];
  clk_gen_pkg::ch_mask_t en_mask;
  clk_gen_pkg::ch_mask_t act_en;

  int     data_errs;
  int     halves_errs;
  int     level_errs;
  int     other_errs;
  int     cycles;
  integer seed;

  clk_gen_top clk_gen_top_i (
    .clk_i     (clk_i),
    .arst_ni   (arst_ni),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o),
    .ch_clk_o  (ch_clk_o),
    .busy_o    (busy_o)
  );

  // 8 ns reference clock
  always #4 clk_i = ~clk_i;

  // watchdog
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // checks

  task automatic check_data(input string name, input clk_gen_pkg::data_t exp,
                            input clk_gen_pkg::data_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected 0x%02h actual 0x%02h", name, exp, act);
      data_errs++;
    end
  endtask

  // d half cycles per phase, one each in bypass
  task automatic check_halves(input string name, input clk_gen_pkg::div_t d,
                              input int hi, input int lo);
    int exp;
    exp = (d < 2) ? 1 : int'(d);
    if (hi != exp || lo != exp) begin
      $display("Mismatch %s: expected high %0d low %0d actual high %0d low %0d",
               name, exp, exp, hi, lo);
      halves_errs++;
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %b actual %b", name, exp, act);
      level_errs++;
    end
  endtask

  ////////////////////////////////////////
  // bus and measurement helpers

  task automatic write_reg(input clk_gen_pkg::addr_t addr, input clk_gen_pkg::data_t data);
    @(posedge clk_i);
    #1;
    wr_en_i   = 1'b1;
    wr_addr_i = addr;
    wr_data_i = data;
    @(posedge clk_i);
    #1;
    wr_en_i = 1'b0;
  endtask

  task automatic read_check(input string name, input clk_gen_pkg::addr_t addr,
                            input clk_gen_pkg::data_t exp);
    @(posedge clk_i);
    #1;
    rd_addr_i = addr;
    #2;
    check_data(name, exp, rd_data_o);
  endtask

  // middle of the next half cycle
  task automatic sample_level(input int ch, output logic lvl);
    @(posedge clk_i or negedge clk_i);
    #2;
    lvl = ch_clk_o[ch];
  endtask

  // busy rises one cycle after the commit pulse
  task automatic wait_idle(input string name);
    int guard;
    @(posedge clk_i);
    #1;
    check_level({name, " busy set"}, 1'b1, busy_o);
    guard = 0;
    while (busy_o && guard < 40) begin
      @(posedge clk_i);
      #1;
      guard++;
    end
    if (busy_o) begin
      $display("ERROR %s: busy_o still high %0d cycles after commit", name, guard);
      other_errs++;
    end
  endtask

  task automatic measure_channel(input string name, input int ch, input clk_gen_pkg::div_t d);
    logic lvl;
    int   hi;
    int   lo;
    int   guard;
    // skip to the first sample of a high phase
    guard = 0;
    sample_level(ch, lvl);
    while (lvl && guard < MAX_HALF) begin
      sample_level(ch, lvl);
      guard++;
    end
    while (!lvl && guard < MAX_HALF) begin
      sample_level(ch, lvl);
      guard++;
    end
    if (guard >= MAX_HALF) begin
      $display("ERROR %s: channel %0d output does not toggle", name, ch);
      other_errs++;
      return;
    end
    for (int p = 0; p < 2; p++) begin
      hi = 0;
      lo = 0;
      while (lvl && hi < MAX_HALF) begin
        hi++;
        sample_level(ch, lvl);
      end
      while (!lvl && lo < MAX_HALF) begin
        lo++;
        sample_level(ch, lvl);
      end
      check_halves($sformatf("%s period %0d", name, p), d, hi, lo);
    end
  endtask

  task automatic hold_low(input string name, input int ch);
    logic lvl;
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < 32; i++) begin
      sample_level(ch, lvl);
      seen = seen | lvl;
    end
    check_level({name, " output held"}, 1'b0, seen);
  endtask

  task automatic set_row(input int r, input string name, input int ch,
                         input clk_gen_pkg::div_t d, input logic en, input logic commit);
    row_name[r]   = name;
    row_ch[r]     = ch;
    row_div[r]    = d;
    row_en[r]     = en;
    row_commit[r] = commit;
  endtask

  ////////////////////////////////////////
  // sequence

  initial begin
    int ch;
    clk_i       = 1'b0;
    arst_ni     = 1'b0;
    wr_en_i     = 1'b0;
    wr_addr_i   = '0;
    wr_data_i   = '0;
    rd_addr_i   = '0;
    data_errs   = 0;
    halves_errs = 0;
    level_errs  = 0;
    other_errs  = 0;
    cycles      = 0;
    seed        = 32'h3e22_96bb;
    en_mask     = '0;
    act_en      = '0;
    for (int i = 0; i < clk_gen_pkg::NUM_CH; i++) begin
      pend_div[i] = '0;
      act_div[i]  = '0;
    end

    set_row(0, "even_2", 0, 4'd2, 1'b1, 1'b1);
    set_row(1, "even_4", 1, 4'd4, 1'b1, 1'b1);
    set_row(2, "even_6", 2, 4'd6, 1'b1, 1'b1);
    set_row(3, "even_14", 3, 4'd14, 1'b1, 1'b1);
    set_row(4, "odd_3", 0, 4'd3, 1'b1, 1'b1);
    set_row(5, "odd_5", 1, 4'd5, 1'b1, 1'b1);
    set_row(6, "odd_9", 2, 4'd9, 1'b1, 1'b1);
    set_row(7, "odd_15", 3, 4'd15, 1'b1, 1'b1);
    set_row(8, "bypass_0", 0, 4'd0, 1'b1, 1'b1);
    set_row(9, "bypass_1", 1, 4'd1, 1'b1, 1'b1);
    set_row(10, "disabled", 2, 4'd4, 1'b0, 1'b1);
    // old ratio 15 must stay active
    set_row(11, "no_commit", 3, 4'd2, 1'b1, 1'b0);
    for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
      set_row(r, $sformatf("random_%0d", r - NUM_FIXED), r % clk_gen_pkg::NUM_CH,
              clk_gen_pkg::div_t'(2 + {$random(seed)} % 14), 1'b1, 1'b1);
    end

    repeat (3) @(posedge clk_i);
    #1;
    arst_ni = 1'b1;
    check_level("reset busy", 1'b0, busy_o);
    check_level("reset clocks", 1'b0, |ch_clk_o);
    for (int a = 0; a < 8; a++) begin
      read_check($sformatf("reset addr %0d", a), clk_gen_pkg::addr_t'(a), '0);
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      ch = row_ch[r];
      // upper nibble set, must be dropped
      write_reg(clk_gen_pkg::addr_t'(ch), 8'ha0 | clk_gen_pkg::data_t'(row_div[r]));
      pend_div[ch] = row_div[r];
      read_check({row_name[r], " ratio"}, clk_gen_pkg::addr_t'(ch),
                 clk_gen_pkg::data_t'(row_div[r]));
      if (row_commit[r]) begin
        en_mask[ch] = row_en[r];
        write_reg(clk_gen_pkg::ADDR_CTRL, clk_gen_pkg::data_t'(en_mask) |
                  (clk_gen_pkg::data_t'(1) << clk_gen_pkg::CTRL_COMMIT_BIT));
        wait_idle(row_name[r]);
        // every channel takes up its pending settings
        for (int i = 0; i < clk_gen_pkg::NUM_CH; i++) begin
          act_div[i] = pend_div[i];
        end
        act_en = en_mask;
        read_check({row_name[r], " ctrl"}, clk_gen_pkg::ADDR_CTRL,
                   clk_gen_pkg::data_t'(en_mask));
      end
      if (act_en[ch]) begin
        measure_channel(row_name[r], ch, act_div[ch]);
      end else begin
        hold_low(row_name[r], ch);
      end
    end

    // unmapped address ignores writes
    write_reg(clk_gen_pkg::addr_t'(5), 8'hff);
    read_check("unused addr", clk_gen_pkg::addr_t'(5), '0);

    $display("errors: data %0d, halves %0d, level %0d, other %0d",
             data_errs, halves_errs, level_errs, other_errs);
    if (data_errs + halves_errs + level_errs + other_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
hw/clk_gen_pkg.sv
hw/div_cfg_if.sv
hw/clk_div.sv
hw/clk_div_channel.sv
hw/div_cfg_regs.sv
hw/clk_gen_top.sv
tests/clk_gen_tb.sv
